// ==== motion_defines.svh ====
`ifndef MOTION_DEFINES_SVH
`define MOTION_DEFINES_SVH

`define MOTION_DATA_W       32
`define MOTION_ADDR_W       5
`define MOTION_NUM_AXES     4
`define MOTION_STEP_BIT_W   5

`define MOTION_A_CTRL       5'd0
`define MOTION_A_DT         5'd1
`define MOTION_A_STEPS      5'd2
`define MOTION_A_PRE        5'd3
`define MOTION_A_PULSE      5'd4
`define MOTION_A_POST       5'd5
`define MOTION_A_GO         5'd6
`define MOTION_A_ABORT      5'd7
`define MOTION_A_VEL0       5'd8
`define MOTION_A_ACC0       5'd9
`define MOTION_A_TICKS      5'd16
`define MOTION_A_STATUS     5'd17

`define MOTION_CTRL_EN_LSB  0
`define MOTION_CTRL_BIT_LSB 4

`endif

// ==== motion_pkg.sv ====
`include "motion_defines.svh"

package motion_pkg;

    // one addressed word of the register bank.
    typedef logic [`MOTION_DATA_W-1:0] reg_word_t;

    typedef logic [`MOTION_ADDR_W-1:0] reg_addr_t;

    // velocity, acceleration and phase share one signed format.
    typedef logic signed [`MOTION_DATA_W-1:0] rate_t;

    // cycle and tick counts.
    typedef logic [`MOTION_DATA_W-1:0] count_t;

    // index of the phase bit whose toggle makes a step.
    typedef logic [`MOTION_STEP_BIT_W-1:0] bit_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        PRE,
        PULSE,
        POST
    } pulse_state_t;

endpackage

// ==== motion_regs.sv ====
`timescale 1ns/1ps
`include "motion_defines.svh"

module motion_regs
    import motion_pkg::*;
(
    input  logic                        osc_clk,
    input  logic                        arst_n,
    input  logic                        reg_wr,
    input  reg_addr_t                   reg_addr,
    input  reg_word_t                   reg_data,
    input  reg_addr_t                   rd_addr,
    input  count_t                      tick_count,
    input  logic                        running,
    output reg_word_t                   rd_data,
    output logic                        go,
    output logic                        abort,
    output count_t                      dt_limit,
    output count_t                      steps_limit,
    output count_t                      pre_n,
    output count_t                      pulse_n,
    output count_t                      post_n,
    output bit_sel_t                    step_bit,
    output logic [`MOTION_NUM_AXES-1:0] enable,
    output rate_t                       vel [`MOTION_NUM_AXES],
    output rate_t                       acc [`MOTION_NUM_AXES]
);

    reg_word_t ctrl;

    assign enable   = ctrl[`MOTION_CTRL_EN_LSB +: `MOTION_NUM_AXES];
    assign step_bit = ctrl[`MOTION_CTRL_BIT_LSB +: `MOTION_STEP_BIT_W];

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            go          <= 1'b0;
            abort       <= 1'b0;
            ctrl        <= '0;
            dt_limit    <= '0;
            steps_limit <= '0;
            pre_n       <= '0;
            pulse_n     <= '0;
            post_n      <= '0;
            for (int k = 0; k < `MOTION_NUM_AXES; k++) begin
                vel[k] <= '0;
                acc[k] <= '0;
            end
        end else begin
            go    <= reg_wr && (reg_addr == `MOTION_A_GO); // strobe only, nothing stored.
            abort <= reg_wr && (reg_addr == `MOTION_A_ABORT);
            if (reg_wr) begin
                case (reg_addr)
                    `MOTION_A_CTRL:  ctrl        <= reg_data;
                    `MOTION_A_DT:    dt_limit    <= reg_data;
                    `MOTION_A_STEPS: steps_limit <= reg_data;
                    `MOTION_A_PRE:   pre_n       <= reg_data;
                    `MOTION_A_PULSE: pulse_n     <= reg_data;
                    `MOTION_A_POST:  post_n      <= reg_data;
                    default: ;
                endcase
                // axis words are interleaved, velocity then acceleration.
                for (int k = 0; k < `MOTION_NUM_AXES; k++) begin
                    if (reg_addr == reg_addr_t'(`MOTION_A_VEL0 + 2 * k)) begin
                        vel[k] <= rate_t'(reg_data);
                    end
                    if (reg_addr == reg_addr_t'(`MOTION_A_ACC0 + 2 * k)) begin
                        acc[k] <= rate_t'(reg_data);
                    end
                end
            end
        end
    end

    always_comb begin
        rd_data = '0; // unmapped and write-only addresses read as zero.
        case (rd_addr)
            `MOTION_A_CTRL:   rd_data = ctrl;
            `MOTION_A_DT:     rd_data = dt_limit;
            `MOTION_A_STEPS:  rd_data = steps_limit;
            `MOTION_A_PRE:    rd_data = pre_n;
            `MOTION_A_PULSE:  rd_data = pulse_n;
            `MOTION_A_POST:   rd_data = post_n;
            `MOTION_A_TICKS:  rd_data = tick_count;
            `MOTION_A_STATUS: rd_data = reg_word_t'(running);
            default: ;
        endcase
        for (int k = 0; k < `MOTION_NUM_AXES; k++) begin
            if (rd_addr == reg_addr_t'(`MOTION_A_VEL0 + 2 * k)) begin
                rd_data = reg_word_t'(vel[k]);
            end
            if (rd_addr == reg_addr_t'(`MOTION_A_ACC0 + 2 * k)) begin
                rd_data = reg_word_t'(acc[k]);
            end
        end
    end

    // a run cannot be started and cancelled by the same strobe.
    a_go_abort_excl: assert property (
        @(posedge osc_clk) disable iff (!arst_n) !(go && abort)
    );

endmodule

// ==== acc_step_gen.sv ====
`timescale 1ns/1ps

module acc_step_gen
    import motion_pkg::*;
(
    input  logic   osc_clk,
    input  logic   arst_n,
    input  logic   go,
    input  logic   abort,
    input  count_t dt_limit,
    input  count_t steps_limit,
    output logic   tick,
    output logic   running,
    output logic   done,
    output count_t tick_count
);

    count_t dt_cnt;

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            dt_cnt     <= '0;
            tick_count <= '0;
            tick       <= 1'b0;
            running    <= 1'b0;
            done       <= 1'b0;
        end else begin
            tick <= 1'b0;
            done <= 1'b0;
            if (go) begin
                dt_cnt     <= '0; // a go during a run starts it over.
                tick_count <= '0;
                running    <= 1'b1;
            end else if (abort) begin
                running <= 1'b0; // tick_count stays for readback.
            end else if (running) begin
                if (dt_cnt + 1 >= dt_limit) begin
                    dt_cnt     <= '0;
                    tick       <= 1'b1;
                    tick_count <= tick_count + 1;
                    if (tick_count + 1 >= steps_limit) begin
                        done    <= 1'b1; // last tick of the run.
                        running <= 1'b0;
                    end
                end else begin
                    dt_cnt <= dt_cnt + 1;
                end
            end
        end
    end

    // the run can only end on a tick boundary.
    a_done_with_tick: assert property (
        @(posedge osc_clk) disable iff (!arst_n) done |-> tick
    );

endmodule

// ==== acc_profile_gen.sv ====
`timescale 1ns/1ps

module acc_profile_gen
    import motion_pkg::*;
(
    input  logic     osc_clk,
    input  logic     arst_n,
    input  logic     go,
    input  logic     tick,
    input  rate_t    vel,
    input  rate_t    acc,
    input  bit_sel_t step_bit,
    output logic     step_req,
    output logic     req_dir
);

    rate_t phase;
    rate_t velocity;
    rate_t accel;
    rate_t phase_next;

    assign phase_next = phase + velocity;

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase    <= '0;
            velocity <= '0;
            accel    <= '0;
            step_req <= 1'b0;
            req_dir  <= 1'b0;
        end else begin
            step_req <= 1'b0;
            if (go) begin
                phase    <= '0;
                velocity <= vel; // profile restarts from the programmed values.
                accel    <= acc;
            end else if (tick) begin
                phase    <= phase_next;
                velocity <= velocity + accel;
                // a toggle of the selected bit in either direction is one step.
                step_req <= phase_next[step_bit] != phase[step_bit];
                req_dir  <= ~velocity[$bits(rate_t)-1];
            end
        end
    end

endmodule

// ==== motor_step_gen.sv ====
`timescale 1ns/1ps

module motor_step_gen
    import motion_pkg::*;
(
    input  logic   osc_clk,
    input  logic   arst_n,
    input  logic   step_req,
    input  logic   req_dir,
    input  count_t pre_n,
    input  count_t pulse_n,
    input  count_t post_n,
    output logic   step,
    output logic   dir
);

    pulse_state_t state;
    count_t       cnt; // cycles spent in the current state.

    always_ff @(posedge osc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            cnt   <= '0;
            step  <= 1'b0;
            dir   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (step_req) begin
                        dir <= req_dir;
                        cnt <= count_t'(1);
                        if (pre_n == '0) begin
                            state <= PULSE; // no setup time asked for.
                            step  <= 1'b1;
                        end else begin
                            state <= PRE;
                        end
                    end
                end
                PRE: begin
                    if (cnt >= pre_n) begin
                        state <= PULSE;
                        step  <= 1'b1;
                        cnt   <= count_t'(1);
                    end else begin
                        cnt <= cnt + 1;
                    end
                end
                PULSE: begin
                    if (cnt >= pulse_n) begin
                        step  <= 1'b0;
                        cnt   <= count_t'(1);
                        state <= (post_n == '0) ? IDLE : POST;
                    end else begin
                        cnt <= cnt + 1;
                    end
                end
                POST: begin
                    if (cnt >= post_n) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt + 1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the tick period must leave room for a whole pulse sequence.
    a_req_in_idle: assert property (
        @(posedge osc_clk) disable iff (!arst_n) step_req |-> state == IDLE
    );

endmodule

// ==== motion_top.sv ====
`timescale 1ns/1ps
`include "motion_defines.svh"

module motion_top
    import motion_pkg::*;
(
    input  logic                        osc_clk,
    input  logic                        arst_n,
    input  logic                        reg_wr,
    input  reg_addr_t                   reg_addr,
    input  reg_word_t                   reg_data,
    input  reg_addr_t                   rd_addr,
    output reg_word_t                   rd_data,
    output logic                        done,
    output logic [`MOTION_NUM_AXES-1:0] motor_step,
    output logic [`MOTION_NUM_AXES-1:0] motor_dir,
    output logic [`MOTION_NUM_AXES-1:0] motor_enable
);

    logic                        go;
    logic                        abort;
    logic                        tick;
    logic                        running;
    count_t                      dt_limit;
    count_t                      steps_limit;
    count_t                      pre_n;
    count_t                      pulse_n;
    count_t                      post_n;
    count_t                      tick_count;
    bit_sel_t                    step_bit;
    rate_t                       vel [`MOTION_NUM_AXES];
    rate_t                       acc [`MOTION_NUM_AXES];
    logic [`MOTION_NUM_AXES-1:0] step_req;
    logic [`MOTION_NUM_AXES-1:0] req_dir;

    motion_regs regs1 (
        .osc_clk     (osc_clk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .rd_addr     (rd_addr),
        .tick_count  (tick_count),
        .running     (running),
        .rd_data     (rd_data),
        .go          (go),
        .abort       (abort),
        .dt_limit    (dt_limit),
        .steps_limit (steps_limit),
        .pre_n       (pre_n),
        .pulse_n     (pulse_n),
        .post_n      (post_n),
        .step_bit    (step_bit),
        .enable      (motor_enable),
        .vel         (vel),
        .acc         (acc)
    );

    acc_step_gen acc_step1 (
        .osc_clk     (osc_clk),
        .arst_n      (arst_n),
        .go          (go),
        .abort       (abort),
        .dt_limit    (dt_limit),
        .steps_limit (steps_limit),
        .tick        (tick),
        .running     (running),
        .done        (done),
        .tick_count  (tick_count)
    );

    // axes x, y, z and a in index order.
    for (genvar k = 0; k < `MOTION_NUM_AXES; k++) begin : g_axis
        acc_profile_gen acc_profile (
            .osc_clk  (osc_clk),
            .arst_n   (arst_n),
            .go       (go),
            .tick     (tick),
            .vel      (vel[k]),
            .acc      (acc[k]),
            .step_bit (step_bit),
            .step_req (step_req[k]),
            .req_dir  (req_dir[k])
        );

        motor_step_gen motor (
            .osc_clk  (osc_clk),
            .arst_n   (arst_n),
            .step_req (step_req[k]),
            .req_dir  (req_dir[k]),
            .pre_n    (pre_n),
            .pulse_n  (pulse_n),
            .post_n   (post_n),
            .step     (motor_step[k]),
            .dir      (motor_dir[k])
        );
    end

endmodule

// ==== tb_motion.sv ====
`timescale 1ns/1ps
`include "motion_defines.svh"

module tb_motion
    import motion_pkg::*;
();

    localparam int NUM_RUNS = 3;

    typedef struct packed {
        logic [31:0] dt;
        logic [31:0] steps;
        logic [4:0]  sbit;
        logic [31:0] pre;
        logic [31:0] pulse;
        logic [31:0] post;
        logic [3:0]  en;
        logic [31:0] abort_at; // ticks before the abort, 0 runs to done.
    } run_t;

    logic      osc_clk = 1'b0;
    logic      arst_n;
    logic      reg_wr;
    reg_addr_t reg_addr;
    reg_word_t reg_data;
    reg_addr_t rd_addr;
    reg_word_t rd_data;
    logic      done;
    logic [3:0] motor_step;
    logic [3:0] motor_dir;
    logic [3:0] motor_enable;

    run_t  runs [NUM_RUNS];
    string names [NUM_RUNS];
    rate_t vel_tab [NUM_RUNS][4];
    rate_t acc_tab [NUM_RUNS][4];
    int    seed;
    string cur_name = "reset";
    int    cur_pre;
    int    cur_pulse;
    int    exp_steps [4];
    logic [3:0] exp_dir = '0;
    int    step_cnt [4] = '{0, 0, 0, 0};
    int    width [4] = '{0, 0, 0, 0};
    int    stable [4] = '{0, 0, 0, 0}; // cycles since dir last changed.
    int    done_cnt = 0;
    logic [3:0] prev_step = '0;
    logic [3:0] prev_dir = '0;

    motion_top i_dut (
        .osc_clk      (osc_clk),
        .arst_n       (arst_n),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .done         (done),
        .motor_step   (motor_step),
        .motor_dir    (motor_dir),
        .motor_enable (motor_enable)
    );

    always #2 osc_clk = ~osc_clk;

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("ERROR %s: %s expected %0d actual %0d", cur_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_word_t d);
        @(posedge osc_clk);
        reg_wr   <= 1'b1;
        reg_addr <= a;
        reg_data <= d;
        @(posedge osc_clk);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_word_t d);
        @(posedge osc_clk);
        rd_addr <= a;
        @(negedge osc_clk);
        d = rd_data;
    endtask

    // phase integration per tick, one step for each toggle of the selected bit.
    task automatic predict_run(input int r);
        rate_t phase;
        rate_t nxt;
        rate_t v;
        for (int k = 0; k < 4; k++) begin
            phase = '0;
            v = vel_tab[r][k];
            exp_steps[k] = 0;
            for (int t = 0; t < int'(runs[r].steps); t++) begin
                nxt = phase + v;
                if (nxt[runs[r].sbit] != phase[runs[r].sbit]) begin
                    exp_steps[k]++;
                    exp_dir[k] = (v >= 0);
                end
                phase = nxt;
                v = v + acc_tab[r][k];
            end
        end
    endtask

    task automatic do_run(input int r);
        reg_word_t rd;
        reg_word_t cfg [6];
        int base_done;
        int mid_steps [4];
        int base_steps [4];
        int waited;
        int limit;
        int quiet;
        cur_name = names[r];
        cur_pre = int'(runs[r].pre);
        cur_pulse = int'(runs[r].pulse);
        quiet = int'(runs[r].pre + runs[r].pulse + runs[r].post) + 5;
        cfg = '{{23'd0, runs[r].sbit, runs[r].en}, runs[r].dt, runs[r].steps,
                runs[r].pre, runs[r].pulse, runs[r].post};
        for (int a = 0; a < 6; a++) begin
            write_reg(reg_addr_t'(`MOTION_A_CTRL + a), cfg[a]);
        end
        for (int k = 0; k < 4; k++) begin
            write_reg(reg_addr_t'(`MOTION_A_VEL0 + 2 * k), vel_tab[r][k]);
            write_reg(reg_addr_t'(`MOTION_A_ACC0 + 2 * k), acc_tab[r][k]);
        end
        for (int a = 0; a < 6; a++) begin
            read_reg(reg_addr_t'(`MOTION_A_CTRL + a), rd);
            check_eq($sformatf("readback of word %0d", a), cfg[a], rd);
        end
        for (int k = 0; k < 4; k++) begin
            read_reg(reg_addr_t'(`MOTION_A_VEL0 + 2 * k), rd);
            check_eq($sformatf("velocity axis %0d", k), vel_tab[r][k], rd);
            read_reg(reg_addr_t'(`MOTION_A_ACC0 + 2 * k), rd);
            check_eq($sformatf("acceleration axis %0d", k), acc_tab[r][k], rd);
        end
        check_eq("motor_enable", 32'(runs[r].en), 32'(motor_enable));
        base_done = done_cnt;
        base_steps = step_cnt;
        write_reg(`MOTION_A_GO, '0);
        if (runs[r].abort_at != 0) begin
            repeat (int'(runs[r].abort_at * runs[r].dt)) @(posedge osc_clk);
            write_reg(`MOTION_A_ABORT, '0);
            read_reg(`MOTION_A_STATUS, rd);
            check_eq("running after abort", 32'd0, rd);
            repeat (quiet) @(posedge osc_clk);
            @(negedge osc_clk);
            mid_steps = step_cnt; // in-flight pulses are done by now.
            // wait past the point where the run would have ended without the abort.
            repeat (int'((runs[r].steps - runs[r].abort_at + 2) * runs[r].dt)) begin
                @(posedge osc_clk);
            end
            @(negedge osc_clk);
            for (int k = 0; k < 4; k++) begin
                check_eq($sformatf("steps after abort axis %0d", k), mid_steps[k], step_cnt[k]);
            end
            read_reg(`MOTION_A_TICKS, rd);
            assert (rd < runs[r].steps) else begin
                $display("ERROR %s: tick count expected below %0d actual %0d",
                         cur_name, runs[r].steps, rd);
                stop_on_failure();
            end
            check_eq("done pulses", 32'd0, done_cnt - base_done);
        end else begin
            predict_run(r);
            limit = (int'(runs[r].steps) + 2) * int'(runs[r].dt);
            waited = 0;
            while (!done && waited < limit) begin
                @(negedge osc_clk);
                waited++;
            end
            assert (done) else begin
                $display("ERROR %s: done did not pulse within %0d cycles", cur_name, limit);
                stop_on_failure();
            end
            repeat (quiet) @(posedge osc_clk);
            @(negedge osc_clk);
            for (int k = 0; k < 4; k++) begin
                check_eq($sformatf("step count axis %0d", k), exp_steps[k],
                         step_cnt[k] - base_steps[k]);
                check_eq($sformatf("dir axis %0d", k), 32'(exp_dir[k]), 32'(motor_dir[k]));
            end
            check_eq("done pulses", 32'd1, done_cnt - base_done);
            read_reg(`MOTION_A_TICKS, rd);
            check_eq("tick count", runs[r].steps, rd);
            read_reg(`MOTION_A_STATUS, rd);
            check_eq("running after done", 32'd0, rd);
        end
    endtask

    // pulse monitors on the motor outputs.
    always @(posedge osc_clk) begin
        if (arst_n) begin
            if (done) begin
                done_cnt++;
            end
            for (int k = 0; k < 4; k++) begin
                if (motor_dir[k] != prev_dir[k]) begin
                    stable[k] = 0;
                end else begin
                    stable[k]++;
                end
                if (motor_step[k] && !prev_step[k]) begin
                    step_cnt[k]++;
                    width[k] = 1;
                    assert (stable[k] >= cur_pre) else begin
                        $display("ERROR %s: dir setup axis %0d expected >= %0d actual %0d",
                                 cur_name, k, cur_pre, stable[k]);
                        stop_on_failure();
                    end
                end else if (motor_step[k]) begin
                    width[k]++;
                end else if (prev_step[k]) begin
                    check_eq($sformatf("step width axis %0d", k), cur_pulse, width[k]);
                end
            end
            prev_step = motor_step;
            prev_dir  = motor_dir;
        end
    end

    initial begin
        int limit;
        limit = 0;
        @(posedge arst_n);
        for (int r = 0; r < NUM_RUNS; r++) begin
            limit += (int'(runs[r].steps) + 2) * int'(runs[r].dt) + 1000;
        end
        repeat (limit) @(posedge osc_clk);
        $display("watchdog expired after %0d cycles and the run did not finish", limit);
        stop_on_failure();
    end

    initial begin
        reg_word_t rd;
        arst_n   = 1'b0;
        reg_wr   = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        rd_addr  = '0;
        seed     = 32'h9c63;
        names[0] = "const_vel";
        runs[0]  = '{32'd12, 32'd40, 5'd8, 32'd2, 32'd3, 32'd2, 4'hf, 32'd0};
        names[1] = "accel_reverse";
        runs[1]  = '{32'd10, 32'd60, 5'd6, 32'd1, 32'd2, 32'd1, 4'h5, 32'd0};
        names[2] = "abort_mid";
        runs[2]  = '{32'd8, 32'd200, 5'd5, 32'd0, 32'd1, 32'd1, 4'ha, 32'd50};
        for (int k = 0; k < 4; k++) begin
            vel_tab[0][k] = $random(seed) % 200; // below 256 so one toggle per tick at most.
            acc_tab[0][k] = '0;
        end
        vel_tab[1] = '{40, -30, 20, 0};
        acc_tab[1] = '{-2, 1, -1, 2}; // axis 0 reverses after twenty ticks.
        vel_tab[2] = '{20, -25, 12, 31};
        acc_tab[2] = '{0, 0, 0, 0};
        repeat (5) @(posedge osc_clk);
        arst_n <= 1'b1;
        @(negedge osc_clk);
        check_eq("motor_step", 32'd0, 32'(motor_step));
        check_eq("motor_dir", 32'd0, 32'(motor_dir));
        check_eq("motor_enable", 32'd0, 32'(motor_enable));
        check_eq("done", 32'd0, 32'(done));
        read_reg(`MOTION_A_STATUS, rd);
        check_eq("status", 32'd0, rd);
        read_reg(`MOTION_A_TICKS, rd);
        check_eq("tick count", 32'd0, rd);
        for (int r = 0; r < NUM_RUNS; r++) begin
            do_run(r);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
motion_pkg.sv
motion_regs.sv
acc_step_gen.sv
acc_profile_gen.sv
motor_step_gen.sv
motion_top.sv
tb_motion.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_motion
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
